// File: hdl/ulaParams.svh
`ifndef ULA_PARAMS_SVH
`define ULA_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Raster geometry in pixel clocks and lines
//////////////////////////////////////////////////////////////////////

`define H_TOTAL       448
`define V_TOTAL       312
`define H_PIXEL_END   255
`define V_PIXEL_END   191
`define H_SYNC_BEGIN  344
`define H_SYNC_END    375
`define V_SYNC_BEGIN  248
`define V_SYNC_END    251

// Frame interrupt length, 32 T-states
`define INT_WIDTH     64

//////////////////////////////////////////////////////////////////////
// CPU port addresses
//////////////////////////////////////////////////////////////////////

`define TIMEX_PORT    8'hFF
`define ULAPLUS_ADDR  16'hBF3B
`define ULAPLUS_DATA  16'hFF3B

// Flash counter bit, toggles every 16 frames
`define FLASH_BIT     4

// Red border out of reset
`define BORDER_RESET  3'b010

`endif

// File: hdl/ulaPkg.sv
package ulaPkg;

   // Plain widths with a meaning
   typedef logic [8:0]  hCount_t;
   typedef logic [8:0]  vCount_t;
   typedef logic [13:0] vramAddr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] cpuAddr_t;
   typedef logic [8:0]  rgb9_t;
   typedef logic [5:0]  paletteIdx_t;

   // Z80 strobe bus as seen by the ULA
   typedef struct packed {
      cpuAddr_t addr;
      byte_t    dataIn;
      logic     mreqN;
      logic     iorqN;
      logic     rdN;
      logic     wrN;
   } cpuBus_t;

   typedef struct packed {
      hCount_t hc;
      vCount_t vc;
   } rasterPos_t;

   // Per-cycle strobes from the fetch sequencer
   typedef struct packed {
      logic serializerLoad;
      logic attrOutputLoad;
      logic borderPaper;
      logic bitmapAddr;
      logic attrAddr;
   } fetchCtl_t;

   typedef struct packed {
      logic [2:0] border;
      logic       screenPage;
      logic       hiColour;
      logic [6:0] paletteReg;
      logic       ulaplusEnabled;
   } ulaConfig_t;

   typedef struct packed {
      rgb9_t rgb;
      logic  hSync;
      logic  vSync;
   } videoOut_t;

   typedef enum logic [2:0] {
      Idle,
      ContendMem,
      ReleaseMem,
      ContendIo,
      ReleaseIo
   } contState_t;

endpackage

// File: hdl/rasterCounters.sv
`include "ulaParams.svh"

module rasterCounters (
   input  logic               clk7,
   input  logic               rst_n,
   output ulaPkg::rasterPos_t pos,
   output logic               frameStart,
   output logic               intN,
   output logic               hSync,
   output logic               vSync
);
   import ulaPkg::*;

   hCount_t hc;
   vCount_t vc;
   logic    lineEnd;

   assign lineEnd = (hc == `H_TOTAL - 1);

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else begin
         hc <= lineEnd ? '0 : hc + 1'b1;
         if (lineEnd) begin
            vc <= (vc == `V_TOTAL - 1) ? '0 : vc + 1'b1;
         end
      end
   end

   assign pos.hc = hc;
   assign pos.vc = vc;

   // Start of vertical retrace drives the flash counter
   assign frameStart = (vc == `V_SYNC_BEGIN) && (hc == 0);
   assign intN = !((vc == `V_SYNC_BEGIN) && (hc < `INT_WIDTH));

   assign hSync = (hc >= `H_SYNC_BEGIN) && (hc <= `H_SYNC_END);
   assign vSync = (vc >= `V_SYNC_BEGIN) && (vc <= `V_SYNC_END);

   // Counters stay inside the raster
   hcRange: assert property (@(posedge clk7) disable iff (!rst_n)
      (hc < `H_TOTAL) && (vc < `V_TOTAL));

endmodule

// File: hdl/vramFetch.sv
`include "ulaParams.svh"

module vramFetch (
   input  logic               clk7,
   input  logic               rst_n,
   input  ulaPkg::rasterPos_t pos,
   input  ulaPkg::ulaConfig_t cfg,
   input  ulaPkg::byte_t      vramData,
   output ulaPkg::fetchCtl_t  ctl,
   output ulaPkg::vramAddr_t  vramAddr,
   output ulaPkg::byte_t      bitmapData,
   output ulaPkg::byte_t      attrData
);
   import ulaPkg::*;

   logic        inPaper;
   logic [3:0]  slot;
   logic [4:0]  colLatch;
   logic [12:0] lineOffset;

   // Paper fetch window runs 8 clocks ahead of the displayed pixels
   assign inPaper = (pos.hc >= 9'd8) && (pos.hc <= `H_PIXEL_END + 8) &&
                    (pos.vc <= `V_PIXEL_END);
   assign slot = pos.hc[3:0];

   //////////////////////////////////////////////////////////////////////
   // Fetch sequence, bitmap at 8/9 and 12/13, attribute at 10/11 and 14/15
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      ctl.serializerLoad = inPaper && (pos.hc[2:0] == 3'd4);
      ctl.attrOutputLoad = (pos.hc[2:0] == 3'd4);
      ctl.borderPaper    = inPaper;
      ctl.bitmapAddr     = inPaper && slot[3] && !slot[1];
      ctl.attrAddr       = inPaper && slot[3] && slot[1];
   end

   // Column for the next two fetch pairs
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         colLatch <= '0;
      end else if (pos.hc[2:0] == 3'd3) begin
         colLatch <= pos.hc[7:3];
      end
   end

   // Thirds, pixel row, character row, column
   assign lineOffset = {pos.vc[7:6], pos.vc[2:0], pos.vc[5:3], colLatch};

   always_comb begin
      if (ctl.bitmapAddr) begin
         vramAddr = {cfg.screenPage, lineOffset};
      end else if (ctl.attrAddr) begin
         if (cfg.hiColour) begin
            vramAddr = {1'b1, lineOffset};
         end else begin
            vramAddr = {cfg.screenPage, 3'b110, pos.vc[7:3], colLatch};
         end
      end else begin
         vramAddr = '0;
      end
   end

   // Data is sampled on the second cycle of each address
   always_ff @(posedge clk7) begin
      if (ctl.bitmapAddr && slot[0]) begin
         bitmapData <= vramData;
      end
      if (ctl.attrAddr && slot[0]) begin
         attrData <= vramData;
      end
   end

   // Attribute fetch always follows its bitmap fetch by two clocks
   fetchOrder: assert property (@(posedge clk7) disable iff (!rst_n)
      ctl.attrAddr |-> !ctl.bitmapAddr && $past(ctl.bitmapAddr, 2));

endmodule

// File: hdl/paletteLut.sv
module paletteLut (
   input  logic                clk7,
   input  logic                rst_n,
   input  logic                we,
   input  ulaPkg::paletteIdx_t wrIdx,
   input  ulaPkg::byte_t       wrData,
   input  ulaPkg::paletteIdx_t paperIdx,
   input  ulaPkg::paletteIdx_t inkIdx,
   input  ulaPkg::paletteIdx_t cpuIdx,
   output ulaPkg::byte_t       paperData,
   output ulaPkg::byte_t       inkData,
   output ulaPkg::byte_t       cpuData
);
   import ulaPkg::*;

   byte_t       mem [0:63];
   paletteIdx_t clearIdx;
   logic        clearing;
   logic        memWe;
   paletteIdx_t memIdx;
   byte_t       memData;

   // Clear sweep after reset, one entry per clock
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         clearIdx <= '0;
         clearing <= 1'b1;
      end else if (clearing) begin
         clearIdx <= clearIdx + 1'b1;
         clearing <= (clearIdx != 6'd63);
      end
   end

   assign memWe   = clearing || we;
   assign memIdx  = clearing ? clearIdx : wrIdx;
   assign memData = clearing ? 8'h00 : wrData;

   always_ff @(posedge clk7) begin
      if (memWe) begin
         mem[memIdx] <= memData;
      end
      paperData <= mem[paperIdx];
      inkData   <= mem[inkIdx];
      cpuData   <= mem[cpuIdx];
   end

endmodule

// File: hdl/pixelPipeline.sv
`include "ulaParams.svh"

module pixelPipeline (
   input  logic                clk7,
   input  logic                rst_n,
   input  logic                frameStart,
   input  logic                hSync,
   input  logic                vSync,
   input  ulaPkg::fetchCtl_t   ctl,
   input  ulaPkg::ulaConfig_t  cfg,
   input  ulaPkg::byte_t       bitmapData,
   input  ulaPkg::byte_t       attrData,
   input  ulaPkg::byte_t       paperData,
   input  ulaPkg::byte_t       inkData,
   output ulaPkg::paletteIdx_t paperIdx,
   output ulaPkg::paletteIdx_t inkIdx,
   output ulaPkg::videoOut_t   video
);
   import ulaPkg::*;

   byte_t       serializer;
   byte_t       attrIn;
   byte_t       attrOut;
   byte_t       attrNow;
   byte_t       plusColour;
   logic        pixelNow;
   logic        pixelFlash;
   logic        pixelReg;
   logic        plusReg;
   logic [4:0]  flashCount;
   logic [12:0] hSyncDly;
   logic [12:0] vSyncDly;
   rgb9_t       stdRgb;

   // IGRB to GGGRRRBBB, half level 101 and bright level 111
   function automatic rgb9_t stdColour(input logic [3:0] igrb);
      logic [2:0] level;
      level = igrb[3] ? 3'b111 : 3'b101;
      return {igrb[2] ? level : 3'b000, igrb[1] ? level : 3'b000,
              igrb[0] ? level : 3'b000};
   endfunction

   // Border colour goes in the paper field
   assign attrIn  = ctl.borderPaper ? attrData : {2'b00, cfg.border, 3'b000};
   assign attrNow = ctl.attrOutputLoad ? attrIn : attrOut;

   // First bit of a cell is taken straight from the data register
   assign pixelNow   = ctl.serializerLoad ? bitmapData[7] : serializer[7];
   assign pixelFlash = pixelNow ^ (attrNow[7] & flashCount[`FLASH_BIT]);

   // ULAplus palette slots for the current cell
   assign paperIdx = {attrNow[7:6], 1'b1, attrNow[5:3]};
   assign inkIdx   = {attrNow[7:6], 1'b0, attrNow[2:0]};

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         serializer <= '0;
         flashCount <= '0;
         hSyncDly   <= '0;
         vSyncDly   <= '0;
      end else begin
         serializer <= ctl.serializerLoad ? {bitmapData[6:0], 1'b0} : {serializer[6:0], 1'b0};
         if (frameStart) begin
            flashCount <= flashCount + 1'b1;
         end
         hSyncDly <= {hSyncDly[11:0], hSync};
         vSyncDly <= {vSyncDly[11:0], vSync};
      end
   end

   // Output stage, lines up with the palette read
   always_ff @(posedge clk7) begin
      if (ctl.attrOutputLoad) begin
         attrOut <= attrIn;
      end
      stdRgb   <= stdColour({attrNow[6], pixelFlash ? attrNow[2:0] : attrNow[5:3]});
      pixelReg <= pixelNow;
      plusReg  <= cfg.ulaplusEnabled;
   end

   assign plusColour = pixelReg ? inkData : paperData;

   // Blue B1 B0 widens to B1 B0 B1
   assign video.rgb   = plusReg ? {plusColour, plusColour[1]} : stdRgb;
   assign video.hSync = hSyncDly[12];
   assign video.vSync = vSyncDly[12];

endmodule

// File: hdl/cpuPorts.sv
`include "ulaParams.svh"

module cpuPorts (
   input  logic               clk7,
   input  logic               rst_n,
   input  ulaPkg::cpuBus_t    bus,
   input  ulaPkg::fetchCtl_t  ctl,
   input  ulaPkg::byte_t      bitmapData,
   input  ulaPkg::byte_t      attrData,
   input  logic               ear,
   input  logic [4:0]         kbd,
   input  ulaPkg::byte_t      cpuData,
   output ulaPkg::ulaConfig_t cfg,
   output logic               paletteWe,
   output ulaPkg::byte_t      dataOut,
   output logic               mic,
   output logic               spk
);
   import ulaPkg::*;

   logic ioWrite;
   logic ioRead;
   logic isPlusAddr;
   logic isPlusData;

   assign ioWrite    = !bus.iorqN && !bus.wrN;
   assign ioRead     = !bus.iorqN && !bus.rdN;
   assign isPlusAddr = (bus.addr == `ULAPLUS_ADDR);
   assign isPlusData = (bus.addr == `ULAPLUS_DATA);

   //////////////////////////////////////////////////////////////////////
   // Port writes
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         cfg.border         <= `BORDER_RESET;
         cfg.screenPage     <= 1'b0;
         cfg.hiColour       <= 1'b0;
         cfg.paletteReg     <= '0;
         cfg.ulaplusEnabled <= 1'b0;
         mic                <= 1'b0;
         spk                <= 1'b0;
      end else if (ioWrite) begin
         if (!bus.addr[0]) begin
            cfg.border <= bus.dataIn[2:0];
            mic        <= bus.dataIn[3];
            spk        <= bus.dataIn[4];
         end else if (bus.addr[7:0] == `TIMEX_PORT) begin
            cfg.screenPage <= bus.dataIn[0];
            cfg.hiColour   <= bus.dataIn[1];
         end else if (isPlusAddr) begin
            cfg.paletteReg <= bus.dataIn[6:0];
         end else if (isPlusData && cfg.paletteReg[6]) begin
            cfg.ulaplusEnabled <= bus.dataIn[0];
         end
      end
   end

   // Group bit clear selects a palette entry
   assign paletteWe = ioWrite && isPlusData && !cfg.paletteReg[6];

   //////////////////////////////////////////////////////////////////////
   // Port reads and floating bus
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      dataOut = 8'hFF;
      if (ioRead) begin
         if (!bus.addr[0]) begin
            dataOut = {1'b1, ear, 1'b1, kbd};
         end else if (isPlusAddr) begin
            dataOut = {1'b0, cfg.paletteReg};
         end else if (isPlusData) begin
            dataOut = cfg.paletteReg[6] ? {7'b0000000, cfg.ulaplusEnabled} : cpuData;
         end else if (ctl.bitmapAddr) begin
            dataOut = bitmapData;
         end else if (ctl.attrAddr) begin
            dataOut = attrData;
         end
      end
   end

endmodule

// File: hdl/contention.sv
`include "ulaParams.svh"

module contention (
   input  logic               clk7,
   input  logic               rst_n,
   input  ulaPkg::rasterPos_t pos,
   input  ulaPkg::fetchCtl_t  ctl,
   input  ulaPkg::cpuBus_t    bus,
   output logic               cpuClk
);
   import ulaPkg::*;

   contState_t state;
   contState_t nextState;
   logic       waitWin;
   logic       stopClk;
   logic       memHit;
   logic       ioHit;

   // ULA owns VRAM for 12 of every 16 paper clocks
   assign waitWin = ctl.borderPaper && (pos.hc[3:0] >= 4'd4);
   assign memHit  = (bus.addr[15:14] == 2'b01);
   assign ioHit   = !bus.iorqN && (!bus.addr[0] || bus.addr == `ULAPLUS_ADDR ||
                                   bus.addr == `ULAPLUS_DATA);

   assign cpuClk = stopClk ? 1'b1 : pos.hc[0];

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         state <= Idle;
      end else begin
         state <= nextState;
      end
   end

   always_comb begin
      nextState = state;
      stopClk   = 1'b0;
      case (state)
         Idle: begin
            // Only stop on a high phase
            if (pos.hc[0] && waitWin) begin
               if (memHit) begin
                  stopClk   = 1'b1;
                  nextState = ContendMem;
               end else if (ioHit) begin
                  stopClk   = 1'b1;
                  nextState = ContendIo;
               end
            end
         end
         ContendMem: begin
            if (waitWin) begin
               stopClk = 1'b1;
            end else begin
               nextState = ReleaseMem;
            end
         end
         ReleaseMem: begin
            if (bus.mreqN) begin
               nextState = Idle;
            end
         end
         ContendIo: begin
            if (waitWin) begin
               stopClk = 1'b1;
            end else begin
               nextState = ReleaseIo;
            end
         end
         ReleaseIo: begin
            if (bus.iorqN) begin
               nextState = Idle;
            end
         end
         default: nextState = Idle;
      endcase
   end

   // Border and retrace lines never slow the CPU
   noBorderStop: assert property (@(posedge clk7) disable iff (!rst_n)
      (pos.vc > `V_PIXEL_END) |-> !stopClk);

endmodule

// File: hdl/ulaTop.sv
module ulaTop (
   input  logic              clk7,
   input  logic              rst_n,
   input  ulaPkg::cpuBus_t   bus,
   input  ulaPkg::byte_t     vramData,
   input  logic              ear,
   input  logic [4:0]        kbd,
   output ulaPkg::byte_t     dataOut,
   output logic              cpuClk,
   output logic              intN,
   output ulaPkg::vramAddr_t vramAddr,
   output ulaPkg::videoOut_t video,
   output logic              mic,
   output logic              spk
);
   import ulaPkg::*;

   rasterPos_t  pos;
   fetchCtl_t   ctl;
   ulaConfig_t  cfg;
   logic        frameStart;
   logic        hSync;
   logic        vSync;
   logic        paletteWe;
   byte_t       bitmapData;
   byte_t       attrData;
   byte_t       paperData;
   byte_t       inkData;
   byte_t       cpuData;
   paletteIdx_t paperIdx;
   paletteIdx_t inkIdx;

   //////////////////////////////////////////////////////////////////////
   // Video side
   //////////////////////////////////////////////////////////////////////

   rasterCounters raster (.clk7(clk7), .rst_n(rst_n), .pos(pos), .frameStart(frameStart),
      .intN(intN), .hSync(hSync), .vSync(vSync));

   vramFetch fetch (.clk7(clk7), .rst_n(rst_n), .pos(pos), .cfg(cfg), .vramData(vramData),
      .ctl(ctl), .vramAddr(vramAddr), .bitmapData(bitmapData), .attrData(attrData));

   pixelPipeline pixels (.clk7(clk7), .rst_n(rst_n), .frameStart(frameStart), .hSync(hSync),
      .vSync(vSync), .ctl(ctl), .cfg(cfg), .bitmapData(bitmapData), .attrData(attrData),
      .paperData(paperData), .inkData(inkData), .paperIdx(paperIdx), .inkIdx(inkIdx),
      .video(video));

   // Palette index and write byte come from the ULAplus ports
   paletteLut palette (.clk7(clk7), .rst_n(rst_n), .we(paletteWe),
      .wrIdx(cfg.paletteReg[5:0]), .wrData(bus.dataIn), .paperIdx(paperIdx), .inkIdx(inkIdx),
      .cpuIdx(cfg.paletteReg[5:0]), .paperData(paperData), .inkData(inkData),
      .cpuData(cpuData));

   //////////////////////////////////////////////////////////////////////
   // CPU side
   //////////////////////////////////////////////////////////////////////

   cpuPorts ports (.clk7(clk7), .rst_n(rst_n), .bus(bus), .ctl(ctl), .bitmapData(bitmapData),
      .attrData(attrData), .ear(ear), .kbd(kbd), .cpuData(cpuData), .cfg(cfg),
      .paletteWe(paletteWe), .dataOut(dataOut), .mic(mic), .spk(spk));

   contention contend (.clk7(clk7), .rst_n(rst_n), .pos(pos), .ctl(ctl), .bus(bus),
      .cpuClk(cpuClk));

endmodule

// File: tests/ulaTb.sv
`include "ulaParams.svh"

module ulaTb;
   timeunit 1ns;
   timeprecision 1ps;
   import ulaPkg::*;

   localparam int Timeout = 200000;

   logic      clk7 = 1'b0;
   logic      rst_n = 1'b0;
   cpuBus_t   bus;
   byte_t     vramData;
   byte_t     dataOut;
   logic      ear;
   logic [4:0] kbd;
   logic      cpuClk;
   logic      intN;
   logic      mic;
   logic      spk;
   vramAddr_t vramAddr;
   videoOut_t video;

   // Shadow of the state the DUT should hold
   byte_t      vBitmap;
   byte_t      vAttr;
   byte_t      palShadow [0:63];
   logic [6:0] palReg;
   logic       plusOn;
   logic [2:0] border;
   int         tbHc;
   int         tbVc;
   logic [4:0] tbFlash;
   logic       tracking = 1'b0;
   int         errors = 0;
   int         checks = 0;
   logic       timedOut = 1'b0;

   ulaTop uut (.clk7(clk7), .rst_n(rst_n), .bus(bus), .vramData(vramData), .ear(ear),
      .kbd(kbd), .dataOut(dataOut), .cpuClk(cpuClk), .intN(intN), .vramAddr(vramAddr),
      .video(video), .mic(mic), .spk(spk));

   always #5 clk7 = ~clk7;

   // Bitmap area of either screen page with attributes above it
   assign vramData = (vramAddr[12:0] < 13'h1800) ? vBitmap : vAttr;

   //////////////////////////////////////////////////////////////////////
   // Raster tracker counting from reset release
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk7) begin
      if (tracking) begin
         if (tbVc == 248 && tbHc == 0) begin
            tbFlash <= tbFlash + 1'b1;
         end
         if (tbHc == 447) begin
            tbHc <= 0;
            tbVc <= (tbVc == 311) ? 0 : tbVc + 1;
         end else begin
            tbHc <= tbHc + 1;
         end
      end
   end

   function automatic logic [2:0] channel(input logic on, input logic bright);
      if (!on) begin
         return 3'b000;
      end
      return bright ? 3'b111 : 3'b101;
   endfunction

   function automatic rgb9_t modelColour(input int vc, input int p);
      byte_t      attr;
      byte_t      entry;
      logic       pix;
      logic [2:0] sel;
      if (vc <= 191 && p <= 255) begin
         attr = vAttr;
         pix  = vBitmap[7 - (p % 8)];
      end else begin
         attr = {2'b00, border, 3'b000};
         pix  = 1'b0;
      end
      if (plusOn) begin
         entry = pix ? palShadow[{attr[7:6], 1'b0, attr[2:0]}]
                     : palShadow[{attr[7:6], 1'b1, attr[5:3]}];
         return {entry, entry[1]};
      end
      pix = pix ^ (attr[7] & tbFlash[4]);
      sel = pix ? attr[2:0] : attr[5:3];
      return {channel(sel[2], attr[6]), channel(sel[1], attr[6]), channel(sel[0], attr[6])};
   endfunction

   task automatic checkValue(input string name, input int got, input int exp);
      checks++;
      assert (got == exp) else begin
         $display("Fail %s got %0h expected %0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic waitPos(input int vc, input int hc);
      int n;
      n = 0;
      while (!(tbVc == vc && tbHc == hc) && n < Timeout && !timedOut) begin
         @(posedge clk7);
         #1;
         n++;
      end
      if (n >= Timeout) begin
         $display("Timed out waiting for raster line %0d pixel %0d", vc, hc);
         timedOut = 1'b1;
      end
   endtask

   task automatic waitIntN(input logic level);
      int n;
      n = 0;
      while (intN !== level && n < Timeout && !timedOut) begin
         @(posedge clk7);
         #1;
         n++;
      end
      if (n >= Timeout) begin
         $display("Timed out waiting for the frame interrupt line");
         timedOut = 1'b1;
      end
   endtask

   task automatic portWrite(input logic [15:0] addr, input byte_t data);
      byte_t d;
      d = data;
      if (addr == `ULAPLUS_DATA && !palReg[6]) begin
         d = $urandom;
      end
      bus.addr   = addr;
      bus.dataIn = d;
      bus.iorqN  = 1'b0;
      bus.wrN    = 1'b0;
      @(posedge clk7);
      #1;
      bus.iorqN = 1'b1;
      bus.wrN   = 1'b1;
      bus.addr  = '0;
      if (!addr[0]) begin
         border = d[2:0];
         checkValue("mic", mic, d[3]);
         checkValue("spk", spk, d[4]);
      end else if (addr == `ULAPLUS_ADDR) begin
         palReg = d[6:0];
      end else if (addr == `ULAPLUS_DATA) begin
         if (palReg[6]) begin
            plusOn = d[0];
         end else begin
            palShadow[palReg[5:0]] = d;
         end
      end
   endtask

   task automatic portRead(input logic [15:0] addr, input byte_t data, input string expStr,
                           input byte_t expV);
      int    n;
      byte_t got;
      byte_t exp;
      n = 0;
      ear = data[5];
      kbd = data[4:0];
      // Unmapped ports only read FF away from the fetch slots
      if (addr[0] && addr != `ULAPLUS_ADDR && addr != `ULAPLUS_DATA) begin
         while (tbVc <= 191 && n < Timeout && !timedOut) begin
            @(posedge clk7);
            #1;
            n++;
         end
         if (n >= Timeout) begin
            $display("Timed out waiting for the lower border before a port read");
            timedOut = 1'b1;
         end
      end
      // Palette reads take one clock
      bus.addr  = addr;
      bus.iorqN = 1'b0;
      bus.rdN   = 1'b0;
      @(posedge clk7);
      #1;
      got = dataOut;
      bus.iorqN = 1'b1;
      bus.rdN   = 1'b1;
      bus.addr  = '0;
      exp = expV;
      if (expStr == "*") begin
         exp = palReg[6] ? {7'b0000000, plusOn} : palShadow[palReg[5:0]];
      end
      checkValue("dataOut", got, exp);
   endtask

   task automatic contendCheck(input logic [15:0] addr, input logic inPaper);
      int vc;
      vc = inPaper ? 50 : 250;
      waitPos(vc, 0);
      waitPos(vc, 36);
      bus.addr  = addr;
      bus.mreqN = 1'b0;
      bus.rdN   = 1'b0;
      for (int k = 0; k < 12; k++) begin
         @(posedge clk7);
         #1;
         if (!inPaper) begin
            checkValue("cpuClk", cpuClk, tbHc % 2);
         end else begin
            checkValue("cpuClk", cpuClk, (tbHc % 16 != 0));
         end
      end
      bus.mreqN = 1'b1;
      bus.rdN   = 1'b1;
      bus.addr  = '0;
   endtask

   // Sync flags of the pixel shown 13 clocks earlier, over one whole line
   task automatic syncSweep(input int vc);
      int pv;
      int ph;
      waitPos(vc, 0);
      repeat (448) begin
         ph = tbHc - 13;
         pv = tbVc;
         if (ph < 0) begin
            ph = ph + 448;
            pv = (pv == 0) ? 311 : pv - 1;
         end
         checkValue("video.hSync", video.hSync, ph >= 344 && ph <= 375);
         checkValue("video.vSync", video.vSync, pv >= 248 && pv <= 251);
         @(posedge clk7);
         #1;
      end
   endtask

   task automatic interruptCheck();
      int n;
      waitIntN(1'b1);
      waitIntN(1'b0);
      checkValue("intN line", tbVc, 248);
      checkValue("intN pixel", tbHc, 0);
      n = 0;
      while (!intN && n < Timeout) begin
         @(posedge clk7);
         #1;
         n++;
      end
      checkValue("intN low cycles", n, `INT_WIDTH);
      while (intN && n < Timeout) begin
         @(posedge clk7);
         #1;
         n++;
      end
      checkValue("intN period", n, 139776);
      syncSweep(248);
      syncSweep(252);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Vector sequencer
   //////////////////////////////////////////////////////////////////////

   initial begin
      int    fd;
      int    testNum;
      string line;
      string op;
      string a;
      string d;
      string e;
      int    av;
      int    dv;
      int    ev;
      void'($urandom(95));
      bus.addr   = 16'h0000;
      bus.dataIn = 8'h00;
      bus.mreqN  = 1'b1;
      bus.iorqN  = 1'b1;
      bus.rdN    = 1'b1;
      bus.wrN    = 1'b1;
      ear     = 1'b0;
      kbd     = 5'h1F;
      vBitmap = 8'h00;
      vAttr   = 8'h00;
      palReg  = '0;
      plusOn  = 1'b0;
      border  = `BORDER_RESET;
      tbFlash = '0;
      tbHc    = 0;
      tbVc    = 0;
      testNum = 0;
      for (int i = 0; i < 64; i++) begin
         palShadow[i] = 8'h00;
      end
      repeat (2) @(posedge clk7);
      #1;
      rst_n    = 1'b1;
      tracking = 1'b1;
      fd = $fopen("tests/ulaVectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file");
         errors++;
      end
      while (fd != 0 && !$feof(fd) && !timedOut) begin
         if ($fgets(line, fd) == 0) begin
            line = "";
         end
         if ($sscanf(line, "%s %s %s %s", op, a, d, e) == 4 && op != "#") begin
            void'($sscanf(a, "%h", av));
            void'($sscanf(d, "%h", dv));
            ev = 0;
            if (e != "*") begin
               void'($sscanf(e, "%h", ev));
            end
            testNum++;
            case (op)
               "W": portWrite(av, dv);
               "R": portRead(av, dv, e, ev);
               "M": begin
                  vBitmap = av;
                  vAttr   = dv;
               end
               "V": begin
                  waitPos(av, 0);
                  waitPos(av, dv + 13);
                  checkValue("video.rgb", video.rgb, modelColour(av, dv));
               end
               "A": begin
                  waitPos(av, 0);
                  waitPos(av, dv);
                  checkValue("vramAddr", vramAddr, ev);
               end
               "C": contendCheck(av, dv[0]);
               "I": interruptCheck();
               "F": begin
                  repeat (dv) begin
                     waitIntN(1'b1);
                     waitIntN(1'b0);
                  end
               end
               default: begin
                  $display("Unknown vector opcode %s", op);
                  errors++;
               end
            endcase
            $display("test %0d %s %s %s finished, %0d errors so far", testNum, op, a, d,
                     errors);
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      $display("%0d tests, %0d checks, %0d errors", testNum, checks, errors);
      if (errors == 0 && !timedOut) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: src.f
+incdir+hdl
hdl/ulaPkg.sv
hdl/rasterCounters.sv
hdl/vramFetch.sv
hdl/paletteLut.sv
hdl/pixelPipeline.sv
hdl/cpuPorts.sv
hdl/contention.sv
hdl/ulaTop.sv
tests/ulaTb.sv

// File: tests/ulaVectors.txt
# op addr data expected, all hex, expected * is taken from the testbench model
# W write port, R read port (data bit 5 ear, bits 4:0 kbd), M bitmap attr, V vc pixel
# A vc hc vramAddr, C addr paper, I interrupt, F frames to wait
R 00FE 1F BF
R 00FE 3A FA
R 1235 00 FF
W BF3B 2A *
R BF3B 00 2A
W FF3B 00 *
R FF3B 00 *
I 0000 00 *
V 00DC 64 *
W 00FE 05 *
V 00DC 64 *
W 00FE 01 *
V 00DC 64 *
M 00FF 47 *
V 0064 64 *
M 0000 47 *
V 0064 64 *
A 0064 28 0C84
W 00FF 01 *
A 0064 28 2C84
W 00FF 00 *
C 5000 01 *
C 5000 00 *
M 00FF B9 *
V 0064 64 *
F 0000 10 *
V 0064 64 *
W 00FE 03 *
W BF3B 0B *
W FF3B 00 *
W BF3B 40 *
W FF3B 01 *
R FF3B 00 01
V 00DC 64 *
M 00FF 47 *
W BF3B 17 *
W FF3B 00 *
V 0064 64 *
